//--- tb/clint_cases.txt
# op addr data strb resp mode, numbers in hex; irq uses data as {soft,timer} and strb as mask
# mode: x exact data, m model data, t mtime range, i mtime increasing, r random data, - none
irq 00000000 0000000000000001 01 0 -
wr 00004000 0123456789abcdef ff 0 -
rd 00004000 0123456789abcdef 00 0 x
wr 00004000 0000000000000000 0f 0 r
rd 00004000 0000000000000000 00 0 m
wr 00004000 0000000000000000 c3 0 r
rd 00004000 0000000000000000 00 0 m
wr 02004000 00000000cafef00d f0 0 -
rd 00004000 0000000000000000 00 0 m
wr 00000000 ffffffff00000001 ff 0 -
irq 00000000 0000000000000002 02 0 -
rd 00000000 0000000000000001 00 0 x
wr 00000000 0000000000000000 01 0 -
irq 00000000 0000000000000000 02 0 -
rd 00000000 0000000000000000 00 0 x
wr 00000000 0000000000000001 fe 0 -
rd 00000000 0000000000000000 00 0 x
wr 0000bff8 0000000100000000 ff 0 -
rd 0000bff8 0000000000000000 00 0 t
rd 0000bff8 0000000000000000 00 0 i
rd 0000bff8 0000000000000000 00 0 i
wr 00001000 0000000000000000 ff 2 r
rd 00001000 0000000000000000 00 2 x
wr 00004004 0000000000000000 ff 2 r
rd 00004000 0000000000000000 00 0 m
wr 00004000 ffffffffffffffff ff 0 -
irq 00000000 0000000000000000 01 0 -
wr 0000bff8 0000000000000010 ff 0 -
wr 00004000 00000000000000d8 ff 0 -
irq 00000000 0000000000000000 01 0 -
twait 00000000 00000000000000c8 00 0 -
stall 00004000 0000000000000000 ff 0 r
stall 00000000 0000000000000001 01 0 -
irq 00000000 0000000000000002 02 0 -
stall 00002000 0000000000000000 ff 2 r

//--- tb.f
+incdir+design
design/clint_pkg.sv
design/clint_axi_slave.sv
design/clint_timer.sv
design/clint_top.sv
tb/clint_properties.sv
tb/clint_tb.sv

//--- Bender.yml
package:
  name: clint

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/clint_pkg.sv
      - design/clint_axi_slave.sv
      - design/clint_timer.sv
      - design/clint_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/clint_properties.sv
      - tb/clint_tb.sv

//--- tb/clint_tb.sv
`timescale 1ns/1ns

`include "clint_macros.svh"

module clint_tb
    import clint_pkg::*;
();

    logic                           clk;
    logic                           rst_n;
    logic [`CLINT_BUS_ADDR_W-1:0]   axi_awaddr;
    logic                           axi_awvalid;
    logic                           axi_awready;
    logic [`CLINT_DATA_W-1:0]       axi_wdata;
    logic [`CLINT_STRB_W-1:0]       axi_wstrb;
    logic                           axi_wvalid;
    logic                           axi_wready;
    logic [1:0]                     axi_bresp;
    logic                           axi_bvalid;
    logic                           axi_bready;
    logic [`CLINT_BUS_ADDR_W-1:0]   axi_araddr;
    logic                           axi_arvalid;
    logic                           axi_arready;
    logic [`CLINT_DATA_W-1:0]       axi_rdata;
    logic [1:0]                     axi_rresp;
    logic                           axi_rvalid;
    logic                           axi_rready;
    logic                           timer_irq;
    logic                           soft_irq;

    // expected register contents, built from the writes issued so far
    logic [63:0]    cmp_m;
    logic           msip_m;
    logic [63:0]    mtime_wr_val;
    int             mtime_wr_cyc;
    logic [63:0]    mtime_last;

    int             cycle;
    int             limit;
    int             seed;
    int             case_err;

    clint_top u_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= limit)
        begin
            $display("timeout: run stopped after %0d cycles without finishing", cycle);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic clint_reg_e target_of(input logic [31:0] addr);
        if (addr[15:0] == `CLINT_MSIP_OFF)
            return reg_msip;
        if (addr[15:0] == `CLINT_MTIMECMP_OFF)
            return reg_mtimecmp;
        if (addr[15:0] == `CLINT_MTIME_OFF)
            return reg_mtime;
        return reg_none;
    endfunction

    function automatic logic [63:0] strobe_merge(input logic [63:0] old_val,
        input logic [63:0] new_val, input logic [7:0] strb);
        logic [63:0] mask;
        for (int i = 0; i < 8; i++)
        begin
            mask[i*8 +: 8] = {8{strb[i]}};
        end
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    function automatic logic [63:0] expected_read(input logic [31:0] addr);
        case (target_of(addr))
            reg_msip:     return {63'd0, msip_m};
            reg_mtimecmp: return cmp_m;
            default:      return 64'd0;
        endcase
    endfunction

    task automatic note_write(input logic [31:0] addr, input logic [63:0] data,
        input logic [7:0] strb, input int hs_cyc);
        case (target_of(addr))
            reg_msip:
            begin
                if (strb[0])
                    msip_m = data[0];
            end
            reg_mtimecmp: cmp_m = strobe_merge(cmp_m, data, strb);
            reg_mtime:
            begin
                // mtime is always written with all strobes set
                mtime_wr_val = data;
                mtime_wr_cyc = hs_cyc;
            end
            default: ;
        endcase
    endtask

    // handshake edge numbers are taken at the negedge before the edge
    task automatic bus_write(input logic [31:0] addr, input logic [63:0] data,
        input logic [7:0] strb, input int stall, output logic [1:0] resp, output int hs_cyc);
        logic [1:0] held;
        @(posedge clk);
        #1;
        axi_awaddr  = addr;
        axi_awvalid = 1'b1;
        axi_wdata   = data;
        axi_wstrb   = strb;
        axi_wvalid  = 1'b1;
        axi_bready  = (stall == 0);
        @(negedge clk);
        while (!axi_awready)
            @(negedge clk);
        assert (axi_wready)
        else
        begin
            $display("[ERROR] %0t: awready high without wready", $time);
            case_err++;
        end
        hs_cyc = cycle + 1;
        @(posedge clk);
        #1;
        axi_awvalid = 1'b0;
        axi_wvalid  = 1'b0;
        @(negedge clk);
        while (!axi_bvalid)
            @(negedge clk);
        held = axi_bresp;
        repeat (stall)
        begin
            @(negedge clk);
            assert (axi_bvalid && axi_bresp == held)
            else
            begin
                $display("[ERROR] %0t: write response changed while bready was low", $time);
                case_err++;
            end
        end
        if (stall > 0)
        begin
            @(posedge clk);
            #1;
            axi_bready = 1'b1;
            @(negedge clk);
        end
        resp = axi_bresp;
        @(posedge clk);
        #1;
        axi_bready = 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] addr, input int stall,
        output logic [63:0] data, output logic [1:0] resp, output int hs_cyc);
        logic [63:0] held;
        @(posedge clk);
        #1;
        axi_araddr  = addr;
        axi_arvalid = 1'b1;
        axi_rready  = (stall == 0);
        @(negedge clk);
        while (!axi_arready)
            @(negedge clk);
        hs_cyc = cycle + 1;
        @(posedge clk);
        #1;
        axi_arvalid = 1'b0;
        @(negedge clk);
        while (!axi_rvalid)
            @(negedge clk);
        held = axi_rdata;
        repeat (stall)
        begin
            @(negedge clk);
            assert (axi_rvalid && axi_rdata == held)
            else
            begin
                $display("[ERROR] %0t: read data changed while rready was low", $time);
                case_err++;
            end
        end
        if (stall > 0)
        begin
            @(posedge clk);
            #1;
            axi_rready = 1'b1;
            @(negedge clk);
        end
        data = axi_rdata;
        resp = axi_rresp;
        @(posedge clk);
        #1;
        axi_rready = 1'b0;
    endtask

    task automatic check_resp(input logic [1:0] got, input axi_resp_e exp_resp);
        assert (got == exp_resp)
        else
        begin
            $display("[ERROR] %0t: response %0d, expected %0d", $time, got, exp_resp);
            case_err++;
        end
    endtask

    task automatic check_read(input logic [31:0] addr, input logic [63:0] exp_data,
        input logic [31:0] mode, input logic [63:0] got, input int hs_cyc);
        logic [63:0] expect_val;
        if (mode == "x" || mode == "m")
        begin
            expect_val = (mode == "x") ? exp_data : expected_read(addr);
            assert (got == expect_val)
            else
            begin
                $display("[ERROR] %0t: read %h gave %h, expected %h", $time, addr, got,
                    expect_val);
                case_err++;
            end
        end
        else if (mode == "t")
        begin
            // at most one count per cycle between the two handshakes
            assert (got >= mtime_wr_val && got - mtime_wr_val <= hs_cyc - mtime_wr_cyc)
            else
            begin
                $display("[ERROR] %0t: mtime %h outside %h plus %0d cycles", $time, got,
                    mtime_wr_val, hs_cyc - mtime_wr_cyc);
                case_err++;
            end
        end
        else if (mode == "i")
        begin
            assert (got > mtime_last)
            else
            begin
                $display("[ERROR] %0t: mtime %h not above previous %h", $time, got, mtime_last);
                case_err++;
            end
        end
        if (target_of(addr) == reg_mtime)
            mtime_last = got;
    endtask

    task automatic check_irq(input logic [1:0] level, input logic [1:0] mask);
        @(negedge clk);
        assert (({soft_irq, timer_irq} & mask) == (level & mask))
        else
        begin
            $display("[ERROR] %0t: soft_irq %b timer_irq %b, expected %b under mask %b",
                $time, soft_irq, timer_irq, level, mask);
            case_err++;
        end
    endtask

    task automatic wait_timer(input int max_cycles);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!timer_irq && waited < max_cycles)
        begin
            @(negedge clk);
            waited++;
        end
        assert (timer_irq)
        else
        begin
            $display("[ERROR] %0t: timer_irq still low after %0d cycles", $time, max_cycles);
            case_err++;
        end
        repeat (32)
        begin
            @(negedge clk);
            assert (timer_irq)
            else
            begin
                $display("[ERROR] %0t: timer_irq dropped after rising", $time);
                case_err++;
            end
        end
    endtask

    initial
    begin : main_seq
        int                 fd;
        int                 rc;
        int                 lines;
        int                 num;
        int                 failed;
        int                 hs_cyc;
        logic [8*16-1:0]    op;
        logic [8*4-1:0]     mode;
        logic [8*256-1:0]   rest;
        logic [31:0]        addr;
        logic [63:0]        data;
        logic [7:0]         strb;
        logic [1:0]         resp_col;
        logic [1:0]         got_resp;
        logic [63:0]        got_data;
        axi_resp_e          exp_resp;

        rst_n        = 1'b0;
        axi_awaddr   = '0;
        axi_awvalid  = 1'b0;
        axi_wdata    = '0;
        axi_wstrb    = '0;
        axi_wvalid   = 1'b0;
        axi_bready   = 1'b0;
        axi_araddr   = '0;
        axi_arvalid  = 1'b0;
        axi_rready   = 1'b0;
        cycle        = 0;
        limit        = 1000;
        seed         = 7273;
        case_err     = 0;
        cmp_m        = '0;
        msip_m       = 1'b0;
        mtime_wr_val = '0;
        mtime_wr_cyc = 0;
        mtime_last   = '0;
        num          = 0;
        failed       = 0;

        // budget of 64 cycles per line of the case file
        lines = 0;
        fd = $fopen("tb/clint_cases.txt", "r");
        if (fd == 0)
        begin
            $display("could not open tb/clint_cases.txt");
            failed = 1;
        end
        else
        begin
            while ($fgets(rest, fd) != 0)
                lines++;
            $fclose(fd);
            limit = lines * 64 + 200;
            fd = $fopen("tb/clint_cases.txt", "r");
        end

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        while (fd != 0 && $fscanf(fd, "%s", op) == 1)
        begin
            if (op == "#")
            begin
                rc = $fgets(rest, fd);
            end
            else
            begin
                rc = $fscanf(fd, "%h %h %h %h %s", addr, data, strb, resp_col, mode);
                num++;
                case_err = 0;
                exp_resp = axi_resp_e'(resp_col);
                if (mode == "r")
                    data = {$random(seed), $random(seed)};
                if (op == "wr")
                begin
                    bus_write(addr, data, strb, 0, got_resp, hs_cyc);
                    check_resp(got_resp, exp_resp);
                    note_write(addr, data, strb, hs_cyc);
                end
                else if (op == "rd")
                begin
                    bus_read(addr, 0, got_data, got_resp, hs_cyc);
                    check_resp(got_resp, exp_resp);
                    check_read(addr, data, mode, got_data, hs_cyc);
                end
                else if (op == "irq")
                begin
                    check_irq(data[1:0], strb[1:0]);
                end
                else if (op == "twait")
                begin
                    wait_timer(data[31:0]);
                end
                else if (op == "stall")
                begin
                    bus_write(addr, data, strb, 5, got_resp, hs_cyc);
                    check_resp(got_resp, exp_resp);
                    note_write(addr, data, strb, hs_cyc);
                    bus_read(addr, 5, got_data, got_resp, hs_cyc);
                    check_resp(got_resp, exp_resp);
                    check_read(addr, data, "m", got_data, hs_cyc);
                end
                else
                begin
                    $display("case file line has an unknown operation: %0s", op);
                    case_err++;
                end
                if (case_err == 0)
                begin
                    $display("case %0d %0s: pass", num, op);
                end
                else
                begin
                    $display("case %0d %0s: fail with %0d errors", num, op, case_err);
                    failed++;
                end
            end
        end
        if (fd != 0)
            $fclose(fd);

        $display("%0d cases run, %0d passed, %0d failed", num, num - failed, failed);
        if (failed == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

//--- tb/clint_properties.sv
`timescale 1ns/1ns

`include "clint_macros.svh"

module clint_properties (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        axi_awvalid,
    input  logic                        axi_awready,
    input  logic                        axi_wvalid,
    input  logic                        axi_wready,
    input  logic [1:0]                  axi_bresp,
    input  logic                        axi_bvalid,
    input  logic                        axi_bready,
    input  logic [`CLINT_DATA_W-1:0]    axi_rdata,
    input  logic                        axi_rvalid,
    input  logic                        axi_rready
);

    // write response held until the master takes it
    bresp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axi_bvalid && !axi_bready |=> axi_bvalid && $stable(axi_bresp))
    else
        $error("bvalid or bresp changed before bready");

    rdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axi_rvalid && !axi_rready |=> axi_rvalid && $stable(axi_rdata))
    else
        $error("rvalid or rdata changed before rready");

    // address and data accepted on the same edge, one cycle only
    aw_w_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (axi_awready || axi_wready) |->
            (axi_awready && axi_wready && axi_awvalid && axi_wvalid)
            ##1 (!axi_awready && !axi_wready))
    else
        $error("awready and wready not a single shared pulse on a full write");

endmodule

bind clint_axi_slave clint_properties u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .axi_awvalid (axi_awvalid),
    .axi_awready (axi_awready),
    .axi_wvalid  (axi_wvalid),
    .axi_wready  (axi_wready),
    .axi_bresp   (axi_bresp),
    .axi_bvalid  (axi_bvalid),
    .axi_bready  (axi_bready),
    .axi_rdata   (axi_rdata),
    .axi_rvalid  (axi_rvalid),
    .axi_rready  (axi_rready)
);

//--- design/clint_top.sv
`timescale 1ns/1ns

`include "clint_macros.svh"

module clint_top
    import clint_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic [`CLINT_BUS_ADDR_W-1:0]    axi_awaddr,
    input  logic                            axi_awvalid,
    output logic                            axi_awready,
    input  logic [`CLINT_DATA_W-1:0]        axi_wdata,
    input  logic [`CLINT_STRB_W-1:0]        axi_wstrb,
    input  logic                            axi_wvalid,
    output logic                            axi_wready,
    output logic [1:0]                      axi_bresp,
    output logic                            axi_bvalid,
    input  logic                            axi_bready,

    input  logic [`CLINT_BUS_ADDR_W-1:0]    axi_araddr,
    input  logic                            axi_arvalid,
    output logic                            axi_arready,
    output logic [`CLINT_DATA_W-1:0]        axi_rdata,
    output logic [1:0]                      axi_rresp,
    output logic                            axi_rvalid,
    input  logic                            axi_rready,

    output logic                            timer_irq,
    output logic                            soft_irq
);

    logic                       wr_en;
    clint_reg_e                 wr_sel;
    logic [`CLINT_DATA_W-1:0]   wdata;
    logic [`CLINT_STRB_W-1:0]   wstrb;
    clint_reg_e                 rd_sel;
    logic [`CLINT_DATA_W-1:0]   rd_data;

    // upper address bits select the CLINT region outside this block
    clint_axi_slave u_slave (
        .clk         (clk),
        .rst_n       (rst_n),
        .axi_awaddr  (axi_awaddr[`CLINT_ADDR_W-1:0]),
        .axi_awvalid (axi_awvalid),
        .axi_awready (axi_awready),
        .axi_wdata   (axi_wdata),
        .axi_wstrb   (axi_wstrb),
        .axi_wvalid  (axi_wvalid),
        .axi_wready  (axi_wready),
        .axi_bresp   (axi_bresp),
        .axi_bvalid  (axi_bvalid),
        .axi_bready  (axi_bready),
        .axi_araddr  (axi_araddr[`CLINT_ADDR_W-1:0]),
        .axi_arvalid (axi_arvalid),
        .axi_arready (axi_arready),
        .axi_rdata   (axi_rdata),
        .axi_rresp   (axi_rresp),
        .axi_rvalid  (axi_rvalid),
        .axi_rready  (axi_rready),
        .wr_en       (wr_en),
        .wr_sel      (wr_sel),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .rd_sel      (rd_sel),
        .rd_data     (rd_data)
    );

    clint_timer u_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_sel    (wr_sel),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .rd_sel    (rd_sel),
        .rd_data   (rd_data),
        .timer_irq (timer_irq),
        .soft_irq  (soft_irq)
    );

endmodule

//--- design/clint_timer.sv
`timescale 1ns/1ns

`include "clint_macros.svh"

module clint_timer
    import clint_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        wr_en,
    input  clint_reg_e                  wr_sel,
    input  logic [`CLINT_DATA_W-1:0]    wdata,
    input  logic [`CLINT_STRB_W-1:0]    wstrb,

    input  clint_reg_e                  rd_sel,
    output logic [`CLINT_DATA_W-1:0]    rd_data,

    output logic                        timer_irq,
    output logic                        soft_irq
);

    logic [`CLINT_DATA_W-1:0]   mtime_q;
    logic [`CLINT_DATA_W-1:0]   mtimecmp_q;
    logic                       msip_q;

    logic                       mtime_wr;
    logic                       mtimecmp_wr;
    logic                       msip_wr;

    // replace only the bytes whose strobe is set
    function automatic logic [`CLINT_DATA_W-1:0] merge_bytes(
        input logic [`CLINT_DATA_W-1:0] old_val,
        input logic [`CLINT_DATA_W-1:0] new_val,
        input logic [`CLINT_STRB_W-1:0] strb
    );
        logic [`CLINT_DATA_W-1:0] res;
        res = old_val;
        for (int i = 0; i < `CLINT_STRB_W; i++)
        begin
            if (strb[i])
            begin
                res[i*8 +: 8] = new_val[i*8 +: 8];
            end
        end
        return res;
    endfunction

    assign mtime_wr    = wr_en && (wr_sel == reg_mtime);
    assign mtimecmp_wr = wr_en && (wr_sel == reg_mtimecmp);
    // msip lives in bit 0, so only byte lane 0 matters
    assign msip_wr     = wr_en && (wr_sel == reg_msip) && wstrb[0];

    // free-running, a write takes precedence over the increment
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mtime_q <= '0;
        end
        else if (mtime_wr)
        begin
            mtime_q <= merge_bytes(mtime_q, wdata, wstrb);
        end
        else
        begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mtimecmp_q <= '0;
        end
        else if (mtimecmp_wr)
        begin
            mtimecmp_q <= merge_bytes(mtimecmp_q, wdata, wstrb);
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            msip_q <= 1'b0;
        end
        else if (msip_wr)
        begin
            msip_q <= wdata[0];
        end
    end

    // read mux, upper msip bits read as zero
    always_comb
    begin
        case (rd_sel)
            reg_msip:     rd_data = {{(`CLINT_DATA_W-1){1'b0}}, msip_q};
            reg_mtimecmp: rd_data = mtimecmp_q;
            reg_mtime:    rd_data = mtime_q;
            default:      rd_data = '0;
        endcase
    end

    // unsigned compare, so cmp at zero after reset fires at once
    assign timer_irq = (mtime_q >= mtimecmp_q);
    assign soft_irq  = msip_q;

endmodule

//--- design/clint_axi_slave.sv
`timescale 1ns/1ns

`include "clint_macros.svh"

module clint_axi_slave
    import clint_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,

    // write address and data
    input  logic [`CLINT_ADDR_W-1:0]    axi_awaddr,
    input  logic                        axi_awvalid,
    output logic                        axi_awready,
    input  logic [`CLINT_DATA_W-1:0]    axi_wdata,
    input  logic [`CLINT_STRB_W-1:0]    axi_wstrb,
    input  logic                        axi_wvalid,
    output logic                        axi_wready,

    // write response
    output logic [1:0]                  axi_bresp,
    output logic                        axi_bvalid,
    input  logic                        axi_bready,

    // read address and data
    input  logic [`CLINT_ADDR_W-1:0]    axi_araddr,
    input  logic                        axi_arvalid,
    output logic                        axi_arready,
    output logic [`CLINT_DATA_W-1:0]    axi_rdata,
    output logic [1:0]                  axi_rresp,
    output logic                        axi_rvalid,
    input  logic                        axi_rready,

    // register side
    output logic                        wr_en,
    output clint_reg_e                  wr_sel,
    output logic [`CLINT_DATA_W-1:0]    wdata,
    output logic [`CLINT_STRB_W-1:0]    wstrb,
    output clint_reg_e                  rd_sel,
    input  logic [`CLINT_DATA_W-1:0]    rd_data
);

    logic                       aw_ready_q;
    logic [`CLINT_ADDR_W-1:0]   aw_addr_q;
    logic                       bvalid_q;
    axi_resp_e                  bresp_q;
    logic                       ar_ready_q;
    logic [`CLINT_ADDR_W-1:0]   ar_addr_q;
    logic                       rvalid_q;
    axi_resp_e                  rresp_q;
    logic [`CLINT_DATA_W-1:0]   rdata_q;

    logic                       aw_start;
    logic                       aw_hs;
    logic                       ar_start;
    logic                       ar_hs;
    clint_reg_e                 aw_sel;
    clint_reg_e                 ar_sel;

    // exact match on the low address bits
    function automatic clint_reg_e decode_addr(input logic [`CLINT_ADDR_W-1:0] addr);
        clint_reg_e sel;
        case (addr)
            `CLINT_MSIP_OFF:     sel = reg_msip;
            `CLINT_MTIMECMP_OFF: sel = reg_mtimecmp;
            `CLINT_MTIME_OFF:    sel = reg_mtime;
            default:             sel = reg_none;
        endcase
        return sel;
    endfunction

    // write accepted only once address and data are both present
    assign aw_start = !aw_ready_q && axi_awvalid && axi_wvalid && !bvalid_q;
    assign aw_hs    = aw_ready_q && axi_awvalid && axi_wvalid;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            aw_ready_q <= 1'b0;
        end
        else if (aw_ready_q)
        begin
            aw_ready_q <= 1'b0;
        end
        else if (aw_start)
        begin
            aw_ready_q <= 1'b1;
        end
    end

    // address is held by the master, so latch it when ready goes up
    always_ff @(posedge clk)
    begin
        if (aw_start)
        begin
            aw_addr_q <= axi_awaddr;
        end
    end

    assign aw_sel = decode_addr(aw_addr_q);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bvalid_q <= 1'b0;
            bresp_q  <= resp_okay;
        end
        else if (aw_hs)
        begin
            bvalid_q <= 1'b1;
            bresp_q  <= (aw_sel == reg_none) ? resp_slverr : resp_okay;
        end
        else if (bvalid_q && axi_bready)
        begin
            bvalid_q <= 1'b0;
        end
    end

    // unmapped writes still complete, just without touching anything
    assign wr_en  = aw_hs && (aw_sel != reg_none);
    assign wr_sel = aw_sel;
    assign wdata  = axi_wdata;
    assign wstrb  = axi_wstrb;

    assign axi_awready = aw_ready_q;
    assign axi_wready  = aw_ready_q;
    assign axi_bvalid  = bvalid_q;
    assign axi_bresp   = bresp_q;

    // read side, one transfer in flight at most
    assign ar_start = !ar_ready_q && axi_arvalid && !rvalid_q;
    assign ar_hs    = ar_ready_q && axi_arvalid;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ar_ready_q <= 1'b0;
        end
        else if (ar_ready_q)
        begin
            ar_ready_q <= 1'b0;
        end
        else if (ar_start)
        begin
            ar_ready_q <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ar_start)
        begin
            ar_addr_q <= axi_araddr;
        end
    end

    assign ar_sel = decode_addr(ar_addr_q);
    assign rd_sel = ar_sel;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rvalid_q <= 1'b0;
            rresp_q  <= resp_okay;
        end
        else if (ar_hs)
        begin
            rvalid_q <= 1'b1;
            rresp_q  <= (ar_sel == reg_none) ? resp_slverr : resp_okay;
        end
        else if (rvalid_q && axi_rready)
        begin
            rvalid_q <= 1'b0;
        end
    end

    // snapshot taken at the handshake, held until rready
    always_ff @(posedge clk)
    begin
        if (ar_hs)
        begin
            rdata_q <= (ar_sel == reg_none) ? '0 : rd_data;
        end
    end

    assign axi_arready = ar_ready_q;
    assign axi_rvalid  = rvalid_q;
    assign axi_rresp   = rresp_q;
    assign axi_rdata   = rdata_q;

endmodule

//--- design/clint_pkg.sv
`include "clint_macros.svh"

package clint_pkg;

    // register targeted by one bus transfer
    typedef enum logic [1:0] {
        reg_none     = 2'd0,
        reg_msip     = 2'd1,
        reg_mtimecmp = 2'd2,
        reg_mtime    = 2'd3
    } clint_reg_e;

    // only the two codes this slave ever returns
    typedef enum logic [1:0] {
        resp_okay   = `CLINT_RESP_OKAY,
        resp_slverr = `CLINT_RESP_SLVERR
    } axi_resp_e;

endpackage

//--- design/clint_macros.svh
`ifndef CLINT_MACROS_SVH
`define CLINT_MACROS_SVH

// address bits seen on the AXI port and the part actually decoded
`define CLINT_BUS_ADDR_W 32
`define CLINT_ADDR_W 16

// data path
`define CLINT_DATA_W 64
`define CLINT_STRB_W 8

// register map, low 16 bits only
`define CLINT_MSIP_OFF 16'h0000
`define CLINT_MTIMECMP_OFF 16'h4000
`define CLINT_MTIME_OFF 16'hBFF8

// AXI response codes
`define CLINT_RESP_OKAY 2'b00
`define CLINT_RESP_SLVERR 2'b10

`endif
